// File: fetch_pkg.sv
package fetch_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////

  // instructions per fetch packet
  localparam int SUPER_W = 2;

  localparam int FETCH_ADDR_W = 16;
  localparam int INST_W       = 32;
  localparam int LINE_W       = 64;
  localparam int BUS_ADDR_W   = 64;
  localparam int MEM_TAG_W    = 4;

  localparam int INST_BYTES = INST_W / 8;
  localparam int LINE_BYTES = LINE_W / 8;
  localparam int LINE_OFF_W = $clog2(LINE_BYTES);

  // direct-mapped split of the fetch address above the line offset
  localparam int CACHE_IDX_W = 5;
  localparam int CACHE_TAG_W = FETCH_ADDR_W - CACHE_IDX_W - LINE_OFF_W;
  localparam int CACHE_LINES = 1 << CACHE_IDX_W;

  ////////////////////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [FETCH_ADDR_W-1:0] fetch_addr_t;
  typedef logic [INST_W-1:0]       inst_t;
  typedef logic [LINE_W-1:0]       line_t;
  typedef logic [BUS_ADDR_W-1:0]   bus_addr_t;

  // zero means no tag
  typedef logic [MEM_TAG_W-1:0] mem_tag_t;

  typedef logic [CACHE_IDX_W-1:0] cache_idx_t;
  typedef logic [CACHE_TAG_W-1:0] cache_tag_t;

  // store is never issued by the front end
  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2
  } bus_cmd_e;

  // slot 0 is the low half of the line, slot 1 the high half
  typedef struct packed {
    inst_t       [SUPER_W-1:0] inst;
    fetch_addr_t [SUPER_W-1:0] npc;
    logic        [SUPER_W-1:0] valid;
  } fetch_packet_t;

endpackage

// File: icache_mem.sv
module icache_mem (
  input  logic                  clock,
  input  logic                  rst_n,
  input  fetch_pkg::cache_idx_t rd_idx,
  input  fetch_pkg::cache_tag_t rd_tag,
  output fetch_pkg::line_t      rd_data,
  output logic                  rd_valid,
  input  logic                  wr_en,
  input  fetch_pkg::cache_idx_t wr_idx,
  input  fetch_pkg::cache_tag_t wr_tag,
  input  fetch_pkg::line_t      wr_data
);

  import fetch_pkg::*;

  line_t                  data_array [CACHE_LINES];
  cache_tag_t             tag_array  [CACHE_LINES];
  logic [CACHE_LINES-1:0] valid_bits;

  // combinational lookup
  assign rd_data  = data_array[rd_idx];
  assign rd_valid = valid_bits[rd_idx] && (tag_array[rd_idx] == rd_tag);

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      valid_bits <= '0;
    end else if (wr_en) begin
      valid_bits[wr_idx] <= 1'b1;
    end
  end

  // fill overwrites line and tag together
  always_ff @(posedge clock) begin
    if (wr_en) begin
      data_array[wr_idx] <= wr_data;
      tag_array[wr_idx]  <= wr_tag;
    end
  end

endmodule

// File: icache_ctrl.sv
module icache_ctrl (
  input  logic                   clock,
  input  logic                   rst_n,
  input  fetch_pkg::fetch_addr_t fetch_addr,
  output fetch_pkg::line_t       line_data,
  output logic                   line_valid,
  input  fetch_pkg::mem_tag_t    mem_response,
  input  fetch_pkg::mem_tag_t    mem_tag,
  input  fetch_pkg::line_t       mem_data,
  output fetch_pkg::bus_cmd_e    mem_command,
  output fetch_pkg::fetch_addr_t mem_addr,
  output fetch_pkg::cache_idx_t  cache_rd_idx,
  output fetch_pkg::cache_tag_t  cache_rd_tag,
  input  fetch_pkg::line_t       cache_rd_data,
  input  logic                   cache_rd_valid,
  output logic                   cache_wr_en,
  output fetch_pkg::cache_idx_t  cache_wr_idx,
  output fetch_pkg::cache_tag_t  cache_wr_tag,
  output fetch_pkg::line_t       cache_wr_data
);

  import fetch_pkg::*;

  // goes high one cycle after reset is released
  logic        lookup_en;
  // a request is in flight, from issue until its fill
  logic        outstanding;
  // accepted bus tag, zero while still waiting for acceptance
  mem_tag_t    pend_tag;
  fetch_addr_t miss_addr;
  fetch_addr_t line_addr;
  logic        miss_start;
  logic        wait_accept;
  logic        fill_hit;

  ////////////////////////////////////////////////////////////////////////////
  // lookup
  ////////////////////////////////////////////////////////////////////////////

  assign cache_rd_idx = fetch_addr[LINE_OFF_W +: CACHE_IDX_W];
  assign cache_rd_tag = fetch_addr[FETCH_ADDR_W-1 -: CACHE_TAG_W];

  // hit result goes straight back to fetch
  assign line_data  = cache_rd_data;
  assign line_valid = cache_rd_valid;

  assign line_addr = {fetch_addr[FETCH_ADDR_W-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};

  ////////////////////////////////////////////////////////////////////////////
  // miss request and fill
  ////////////////////////////////////////////////////////////////////////////

  // only one miss at a time, a new one waits for the fill
  assign miss_start  = lookup_en && !cache_rd_valid && !outstanding;
  assign wait_accept = outstanding && (pend_tag == '0);
  assign fill_hit    = outstanding && (pend_tag != '0) && (mem_tag == pend_tag);

  // address is held from the registered copy once issued
  assign mem_command = (miss_start || wait_accept) ? BUS_LOAD : BUS_NONE;
  assign mem_addr    = outstanding ? miss_addr : line_addr;

  assign cache_wr_en   = fill_hit;
  assign cache_wr_idx  = miss_addr[LINE_OFF_W +: CACHE_IDX_W];
  assign cache_wr_tag  = miss_addr[FETCH_ADDR_W-1 -: CACHE_TAG_W];
  assign cache_wr_data = mem_data;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      lookup_en   <= 1'b0;
      outstanding <= 1'b0;
      pend_tag    <= '0;
    end else begin
      lookup_en <= 1'b1;
      if (miss_start) begin
        // may be accepted in the same cycle
        outstanding <= 1'b1;
        pend_tag    <= mem_response;
      end else if (wait_accept) begin
        pend_tag <= mem_response;
      end else if (fill_hit) begin
        outstanding <= 1'b0;
        pend_tag    <= '0;
      end
    end
  end

  // the line being fetched, kept across a redirect
  always_ff @(posedge clock) begin
    if (miss_start) begin
      miss_addr <= line_addr;
    end
  end

endmodule

// File: fetch_stage.sv
module fetch_stage (
  input  logic                     clock,
  input  logic                     rst_n,
  input  logic                     redirect_en,
  input  fetch_pkg::fetch_addr_t   redirect_pc,
  input  logic                     fetch_en,
  input  fetch_pkg::line_t         line_data,
  input  logic                     line_valid,
  output fetch_pkg::fetch_addr_t   fetch_addr,
  output fetch_pkg::fetch_packet_t fetch_packet,
  output logic                     fetch_packet_valid
);

  import fetch_pkg::*;

  fetch_addr_t pc;
  fetch_addr_t pc_next;
  fetch_addr_t redirect_line;
  logic        advance;

  assign fetch_addr = pc;

  // the PC always points at a whole line
  assign redirect_line = {redirect_pc[FETCH_ADDR_W-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};
  assign advance       = line_valid && fetch_en;

  // redirect wins over the advance
  always_comb begin
    if (redirect_en) begin
      pc_next = redirect_line;
    end else if (advance) begin
      pc_next = pc + fetch_addr_t'(LINE_BYTES);
    end else begin
      pc_next = pc;
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // packet assembly
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < SUPER_W; i++) begin
      fetch_packet.inst[i]  = line_data[i*INST_W +: INST_W];
      fetch_packet.npc[i]   = pc + fetch_addr_t'((i + 1) * INST_BYTES);
      fetch_packet.valid[i] = line_valid;
    end
  end

  // a line read in the redirect cycle is stale
  assign fetch_packet_valid = line_valid && !redirect_en;

endmodule

// File: fetch_buffer.sv
module fetch_buffer #(
  parameter int FB_DEPTH = 8
) (
  input  logic                     clock,
  input  logic                     rst_n,
  input  logic                     flush,
  input  fetch_pkg::fetch_packet_t in_packet,
  input  logic                     in_valid,
  output logic                     fetch_en,
  output fetch_pkg::fetch_packet_t out_packet,
  output logic                     out_valid,
  input  logic                     out_ready
);

  import fetch_pkg::*;

  localparam int PTR_W = $clog2(FB_DEPTH);
  localparam int CNT_W = PTR_W + 1;
  localparam logic [CNT_W-1:0] DEPTH_CNT = CNT_W'(FB_DEPTH);

  fetch_packet_t    entries [FB_DEPTH];
  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] tail;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             push;
  logic             pop;

  assign full     = (count == DEPTH_CNT);
  assign fetch_en = !full;

  assign out_valid  = (count != '0);
  assign out_packet = entries[head];

  // nothing enters in the flush cycle
  assign push = in_valid && !full && !flush;
  assign pop  = out_valid && out_ready;

  ////////////////////////////////////////////////////////////////////////////
  // pointers and occupancy
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else if (flush) begin
      // drop everything in one edge
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (push) begin
        tail <= tail + PTR_W'(1);
      end
      if (pop) begin
        head <= head + PTR_W'(1);
      end
      case ({push, pop})
        2'b10: begin
          count <= count + CNT_W'(1);
        end
        2'b01: begin
          count <= count - CNT_W'(1);
        end
        default: begin
          count <= count;
        end
      endcase
    end
  end

  // storage
  always_ff @(posedge clock) begin
    if (push) begin
      entries[tail] <= in_packet;
    end
  end

endmodule

// File: front_end.sv
module front_end #(
  parameter int FB_DEPTH = 8
) (
  input  logic                     clock,
  input  logic                     rst_n,
  input  fetch_pkg::mem_tag_t      mem2proc_response,
  input  fetch_pkg::line_t         mem2proc_data,
  input  fetch_pkg::mem_tag_t      mem2proc_tag,
  input  logic                     dispatch_ready,
  input  logic                     redirect_en,
  input  fetch_pkg::fetch_addr_t   redirect_pc,
  output fetch_pkg::bus_cmd_e      proc2mem_command,
  output fetch_pkg::bus_addr_t     proc2mem_addr,
  output fetch_pkg::line_t         proc2mem_data,
  output fetch_pkg::fetch_packet_t dispatch_packet,
  output logic                     dispatch_valid
);

  import fetch_pkg::*;

  fetch_addr_t   fetch_addr;
  line_t         line_data;
  logic          line_valid;
  fetch_addr_t   mem_addr;
  cache_idx_t    cache_rd_idx;
  cache_tag_t    cache_rd_tag;
  line_t         cache_rd_data;
  logic          cache_rd_valid;
  logic          cache_wr_en;
  cache_idx_t    cache_wr_idx;
  cache_tag_t    cache_wr_tag;
  line_t         cache_wr_data;
  fetch_packet_t fetch_packet;
  logic          fetch_packet_valid;
  logic          fetch_en;

  // fetch space is 16 bits, upper bus address bits stay zero
  assign proc2mem_addr = bus_addr_t'(mem_addr);
  // instruction fetch never writes
  assign proc2mem_data = '0;

  icache_mem u_icache_mem (
    .clock    (clock),
    .rst_n    (rst_n),
    .rd_idx   (cache_rd_idx),
    .rd_tag   (cache_rd_tag),
    .rd_data  (cache_rd_data),
    .rd_valid (cache_rd_valid),
    .wr_en    (cache_wr_en),
    .wr_idx   (cache_wr_idx),
    .wr_tag   (cache_wr_tag),
    .wr_data  (cache_wr_data)
  );

  icache_ctrl u_icache_ctrl (
    .clock          (clock),
    .rst_n          (rst_n),
    .fetch_addr     (fetch_addr),
    .line_data      (line_data),
    .line_valid     (line_valid),
    .mem_response   (mem2proc_response),
    .mem_tag        (mem2proc_tag),
    .mem_data       (mem2proc_data),
    .mem_command    (proc2mem_command),
    .mem_addr       (mem_addr),
    .cache_rd_idx   (cache_rd_idx),
    .cache_rd_tag   (cache_rd_tag),
    .cache_rd_data  (cache_rd_data),
    .cache_rd_valid (cache_rd_valid),
    .cache_wr_en    (cache_wr_en),
    .cache_wr_idx   (cache_wr_idx),
    .cache_wr_tag   (cache_wr_tag),
    .cache_wr_data  (cache_wr_data)
  );

  fetch_stage u_fetch_stage (
    .clock              (clock),
    .rst_n              (rst_n),
    .redirect_en        (redirect_en),
    .redirect_pc        (redirect_pc),
    .fetch_en           (fetch_en),
    .line_data          (line_data),
    .line_valid         (line_valid),
    .fetch_addr         (fetch_addr),
    .fetch_packet       (fetch_packet),
    .fetch_packet_valid (fetch_packet_valid)
  );

  // redirect also flushes the queue
  fetch_buffer #(
    .FB_DEPTH (FB_DEPTH)
  ) u_fetch_buffer (
    .clock      (clock),
    .rst_n      (rst_n),
    .flush      (redirect_en),
    .in_packet  (fetch_packet),
    .in_valid   (fetch_packet_valid),
    .fetch_en   (fetch_en),
    .out_packet (dispatch_packet),
    .out_valid  (dispatch_valid),
    .out_ready  (dispatch_ready)
  );

endmodule

// File: tb_front_end_sva.sv
module front_end_sva (
  input logic                 clock,
  input logic                 rst_n,
  input fetch_pkg::bus_cmd_e  proc2mem_command,
  input fetch_pkg::bus_addr_t proc2mem_addr,
  input fetch_pkg::mem_tag_t  mem2proc_response,
  input logic                 dispatch_valid
);

  import fetch_pkg::*;

  // request held until a nonzero response tag takes it
  property load_held_until_accepted;
    @(posedge clock) disable iff (!rst_n)
      (proc2mem_command == BUS_LOAD && mem2proc_response == '0)
      |=> (proc2mem_command == BUS_LOAD && $stable(proc2mem_addr));
  endproperty

  property no_dispatch_after_reset;
    @(posedge clock) $rose(rst_n) |-> !dispatch_valid;
  endproperty

  property no_store_command;
    @(posedge clock) disable iff (!rst_n) proc2mem_command != BUS_STORE;
  endproperty

  assert property (load_held_until_accepted)
    else $error("bus command or address changed before acceptance");
  assert property (no_dispatch_after_reset)
    else $error("dispatch_valid high in the first cycle after reset");
  assert property (no_store_command)
    else $error("front end drove BUS_STORE");

endmodule

bind front_end front_end_sva u_front_end_sva (
  .clock             (clock),
  .rst_n             (rst_n),
  .proc2mem_command  (proc2mem_command),
  .proc2mem_addr     (proc2mem_addr),
  .mem2proc_response (mem2proc_response),
  .dispatch_valid    (dispatch_valid)
);

// File: tb_front_end.sv
module tb_front_end;

  import fetch_pkg::*;

  localparam logic [31:0] SEED       = 32'h9d63_ab31;
  localparam int          LOOP_LINES = 16;

  logic          clock             = 1'b0;
  logic          rst_n             = 1'b0;
  mem_tag_t      mem2proc_response = '0;
  line_t         mem2proc_data     = '0;
  mem_tag_t      mem2proc_tag      = '0;
  logic          dispatch_ready    = 1'b0;
  logic          redirect_en       = 1'b0;
  fetch_addr_t   redirect_pc       = '0;
  bus_cmd_e      proc2mem_command;
  bus_addr_t     proc2mem_addr;
  line_t         proc2mem_data;
  fetch_packet_t dispatch_packet;
  logic          dispatch_valid;

  // memory model and ready state
  logic [31:0]   bus_rng     = SEED;
  mem_tag_t      next_tag    = 4'h1;
  logic [1:0]    accept_wait = '0;
  logic          reply_busy  = 1'b0;
  logic [2:0]    reply_wait  = '0;
  mem_tag_t      reply_tag   = '0;
  fetch_addr_t   reply_addr  = '0;
  logic          ready_low   = 1'b0;
  logic          watch_loop  = 1'b0;
  fetch_addr_t   loop_start  = '0;
  fetch_addr_t   exp_pc      = '0;
  int            consumed    = 0;

  front_end #(
    .FB_DEPTH (8)
  ) DUT (
    .clock             (clock),
    .rst_n             (rst_n),
    .mem2proc_response (mem2proc_response),
    .mem2proc_data     (mem2proc_data),
    .mem2proc_tag      (mem2proc_tag),
    .dispatch_ready    (dispatch_ready),
    .redirect_en       (redirect_en),
    .redirect_pc       (redirect_pc),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .proc2mem_data     (proc2mem_data),
    .dispatch_packet   (dispatch_packet),
    .dispatch_valid    (dispatch_valid)
  );

  always #2 clock = ~clock;

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // fixed hash of the line address
  function automatic line_t mem_line(input fetch_addr_t addr);
    logic [31:0] a;
    logic [31:0] lo;
    logic [31:0] hi;
    a  = {16'h0000, addr[15:3], 3'b000};
    lo = (a * 32'h9e37_79b1) ^ 32'h7f4a_7c15;
    hi = ((a ^ 32'h85eb_ca6b) * 32'hc2b2_ae35) ^ (lo >> 7);
    return {hi, lo};
  endfunction

  // low word of a line sits at the lower address
  function automatic inst_t expected_inst(input fetch_addr_t pc);
    line_t line;
    line = mem_line(pc);
    return pc[2] ? line[63:32] : line[31:0];
  endfunction

  function automatic fetch_addr_t expected_npc(input fetch_addr_t pc);
    return pc + fetch_addr_t'(4);
  endfunction

  function automatic logic in_loop(input fetch_addr_t addr);
    return (addr >= loop_start) && (addr < loop_start + fetch_addr_t'(LOOP_LINES * 8));
  endfunction

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped after a failed check");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("[ERROR] t=%0t %s got %h expected %h",
                                  $time, name, got, exp));
    end
  endtask

  task automatic compare_packet(input fetch_addr_t line_pc, input fetch_packet_t pkt);
    fetch_addr_t slot_pc;
    for (int i = 0; i < SUPER_W; i++) begin
      slot_pc = line_pc + fetch_addr_t'(4 * i);
      check_value($sformatf("dispatch_packet.inst[%0d]", i),
                  64'(pkt.inst[i]), 64'(expected_inst(slot_pc)));
      check_value($sformatf("dispatch_packet.npc[%0d]", i),
                  64'(pkt.npc[i]), 64'(expected_npc(slot_pc)));
      check_value($sformatf("dispatch_packet.valid[%0d]", i),
                  64'(pkt.valid[i]), 64'd1);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // memory model and dispatch ready
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clock) begin
    bus_rng = xorshift32(bus_rng);
    dispatch_ready <= ready_low ? 1'b0 : bus_rng[8];
    if (!rst_n) begin
      mem2proc_response <= '0;
      mem2proc_tag      <= '0;
      reply_busy        <= 1'b0;
      next_tag          <= 4'h1;
      accept_wait       <= '0;
    end else begin
      check_value("proc2mem_data", proc2mem_data, 64'd0);
      if (proc2mem_command == BUS_LOAD) begin
        // line address zero-extended onto the bus
        check_value("proc2mem_addr", proc2mem_addr, {48'h0, proc2mem_addr[15:3], 3'b000});
      end
      if (proc2mem_command == BUS_LOAD && watch_loop && in_loop(proc2mem_addr[15:0])) begin
        stop_with_failure($sformatf("unexpected BUS_LOAD to resident loop line %h at %0t",
                                    proc2mem_addr[15:0], $time));
      end
      // reply tag lasts one cycle and data is junk otherwise
      if (reply_busy && reply_wait == 3'd0) begin
        mem2proc_tag  <= reply_tag;
        mem2proc_data <= mem_line(reply_addr);
        reply_busy    <= 1'b0;
      end else begin
        mem2proc_tag  <= '0;
        mem2proc_data <= {bus_rng, ~bus_rng};
        if (reply_busy) begin
          reply_wait <= reply_wait - 3'd1;
        end
      end
      // the DUT takes the acceptance tag at this edge
      if (mem2proc_response != '0) begin
        mem2proc_response <= '0;
        if (proc2mem_command == BUS_LOAD) begin
          reply_addr <= proc2mem_addr[15:0];
          reply_tag  <= mem2proc_response;
          reply_wait <= bus_rng[2:0];
          reply_busy <= 1'b1;
        end
      end else if (proc2mem_command == BUS_LOAD) begin
        if (accept_wait == 2'd0) begin
          mem2proc_response <= next_tag;
          next_tag          <= (next_tag == 4'hf) ? 4'h1 : next_tag + 4'h1;
          accept_wait       <= bus_rng[5:4];
        end else begin
          accept_wait <= accept_wait - 2'd1;
        end
      end
    end
  end

  // compare at every consuming edge
  // a redirect edge drops the buffer and restarts the expected line
  always @(posedge clock) begin
    if (!rst_n) begin
      exp_pc <= '0;
    end else if (redirect_en) begin
      exp_pc <= {redirect_pc[15:3], 3'b000};
    end else if (dispatch_valid && dispatch_ready) begin
      compare_packet(exp_pc, dispatch_packet);
      exp_pc   <= exp_pc + fetch_addr_t'(8);
      consumed <= consumed + 1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // sequence
  ////////////////////////////////////////////////////////////////////////////

  task automatic wait_consumed(input int n, input int limit);
    int target;
    int cycles;
    target = consumed + n;
    cycles = 0;
    while (consumed < target) begin
      @(posedge clock);
      cycles++;
      if (cycles > limit) begin
        stop_with_failure($sformatf("timeout after %0d cycles waiting for %0d packets",
                                    limit, n));
      end
    end
  endtask

  task automatic wait_buffer_full(input int limit);
    int cycles;
    cycles = 0;
    do begin
      @(posedge clock);
      cycles++;
      if (cycles > limit) begin
        stop_with_failure("timeout waiting for the fetch buffer to fill");
      end
    end while (DUT.fetch_en !== 1'b0);
  endtask

  // returns at the edge that takes the redirect
  task automatic redirect_to(input fetch_addr_t target);
    @(posedge clock);
    redirect_en <= 1'b1;
    redirect_pc <= target;
    @(posedge clock);
    redirect_en <= 1'b0;
  endtask

  initial begin : sequence_main
    logic [31:0] seq_rng;
    fetch_addr_t target;
    seq_rng = ~SEED;
    repeat (4) @(posedge clock);
    rst_n <= 1'b1;
    @(posedge clock);
    check_value("proc2mem_command", 64'(proc2mem_command), 64'(BUS_NONE));
    check_value("dispatch_valid", 64'(dispatch_valid), 64'd0);

    // straight stream from pc 0 over more lines than the cache holds
    wait_consumed(72, 4000);

    // random targets, unaligned on purpose
    for (int r = 0; r < 4; r++) begin
      seq_rng = xorshift32(seq_rng);
      redirect_to(seq_rng[15:0]);
      wait_consumed(12, 1500);
    end

    // first pass over the loop fills its lines
    seq_rng = xorshift32(seq_rng);
    target = {1'b0, seq_rng[14:3], 3'b000};
    loop_start <= target;
    redirect_to(target | fetch_addr_t'(seq_rng[18:16]));
    wait_consumed(LOOP_LINES, 2000);

    // second pass must hit, with a full-buffer stall on the way
    watch_loop <= 1'b1;
    ready_low  <= 1'b1;
    redirect_to(target);
    wait_buffer_full(200);
    ready_low <= 1'b0;
    wait_consumed(LOOP_LINES, 1000);
    watch_loop <= 1'b0;

    $display("RESULT: PASS");
    $finish;
  end

endmodule

// File: files.f
fetch_pkg.sv
icache_mem.sv
icache_ctrl.sv
fetch_stage.sv
fetch_buffer.sv
front_end.sv
tb_front_end_sva.sv
tb_front_end.sv

// File: run.sh
#!/bin/sh
# build and run the front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_front_end \
  -f files.f \
  -Mdir obj_dir -o sim_front_end
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit $build_status
fi

./obj_dir/sim_front_end
sim_status=$?
if [ $sim_status -ne 0 ]; then
  echo "simulation failed with status $sim_status"
  exit $sim_status
fi

exit 0
